// ==== build.f ====
+incdir+hw
hw/ocl_bus_pkg.sv
hw/ocl_regs_pkg.sv
hw/hello_vled.sv
hw/tick_counter.sv
hw/ocl_slave.sv
hw/cl_hello_top.sv
test/tb_cl_hello_top.sv

// ==== hw/cl_hello_top.sv ====
// ------------------------------------------------
// Hello-world custom logic top
// ------------------------------------------------
module cl_hello_top
  import ocl_bus_pkg::*;
  import ocl_regs_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  // AXI4-Lite slave
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  input  logic       wvalid,
  input  axil_data_t wdata,
  output logic       wready,
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready,
  // Virtual switches and LEDs
  input  vled_t      status_vdip,
  output vled_t      status_vled
);

  // Register strobes and shared write data
  logic       hello_wr;
  logic       ctrl_wr;
  logic       tick_wr;
  logic       load_wr;
  logic       mark_wr;
  axil_data_t wr_data;

  // Read-back sources
  axil_data_t hello_swapped;
  vled_t      vled_value;
  axil_data_t cnt_status;

  // ------------------------------------------------
  // Bus slave
  // ------------------------------------------------
  ocl_slave ocl_slave_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .hello_wr        (hello_wr),
    .ctrl_wr         (ctrl_wr),
    .tick_wr         (tick_wr),
    .load_wr         (load_wr),
    .mark_wr         (mark_wr),
    .wr_data         (wr_data),
    .hello_swapped   (hello_swapped),
    .vled_value      (vled_value),
    .cnt_status      (cnt_status)
  );

  // ------------------------------------------------
  // Register blocks
  // ------------------------------------------------
  hello_vled hello_vled_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_wr        (hello_wr),
    .wr_data         (wr_data),
    .status_vdip     (status_vdip),
    .hello_swapped   (hello_swapped),
    .vled_value      (vled_value),
    .status_vled     (status_vled)
  );

  tick_counter tick_counter_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ctrl_wr         (ctrl_wr),
    .tick_wr         (tick_wr),
    .load_wr         (load_wr),
    .mark_wr         (mark_wr),
    .wr_data         (wr_data),
    .cnt_status      (cnt_status)
  );

endmodule

// ==== hw/hello_vled.sv ====
// ------------------------------------------------
// Hello-world and virtual LED registers
// ------------------------------------------------
module hello_vled
  import ocl_bus_pkg::*;
  import ocl_regs_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       hello_wr,
  input  axil_data_t wr_data,
  input  vled_t      status_vdip,
  output axil_data_t hello_swapped,
  output vled_t      vled_value,
  output vled_t      status_vled
);

  axil_data_t hello_q;
  vled_t      vdip_q;
  vled_t      vdip_q2;

  // ------------------------------------------------
  // Hello-world word
  // ------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
    end else if (hello_wr) begin
      hello_q <= wr_data;
    end
  end

  // Read back with byte order reversed
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // ------------------------------------------------
  // LED shadow and DIP masking
  // ------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_value  <= '0;
      vdip_q      <= '0;
      vdip_q2     <= '0;
      status_vled <= '0;
    end else begin
      // Shadow lags the hello-world word by a cycle
      vled_value  <= hello_q[$bits(vled_t)-1:0];
      // Two-stage DIP synchronizer
      vdip_q      <= status_vdip;
      vdip_q2     <= vdip_q;
      // LEDs only light where the DIP switch is on
      status_vled <= vled_value & vdip_q2;
    end
  end

  // LED never lit where the DIP input was off three edges earlier
  a_vled_masked: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (status_vled & ~$past(status_vdip, 3)) == '0
  );

endmodule

// ==== hw/ocl_bus_pkg.sv ====
// ------------------------------------------------
// AXI4-Lite bus types
// ------------------------------------------------
`include "ocl_settings.svh"

package ocl_bus_pkg;

  // Address and data words
  typedef logic [`OCL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`OCL_DATA_W-1:0] axil_data_t;

  // Response code
  typedef logic [1:0] axil_resp_t;

  // Only OKAY is ever returned
  localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

endpackage

// ==== hw/ocl_regs_pkg.sv ====
// ------------------------------------------------
// Register field types
// ------------------------------------------------
`include "ocl_settings.svh"

package ocl_regs_pkg;

  // Virtual LED or DIP word
  typedef logic [`OCL_VLED_W-1:0] vled_t;

  // Main count
  typedef logic [`OCL_COUNT_W-1:0] count_t;

  // Prescaler value
  typedef logic [`OCL_TICK_W-1:0] tick_t;

  // Counter controls
  // Member order mirrors the control word, enable in the LSB
  typedef struct packed {
    logic oneshot;
    logic clear;
    logic load;
    logic enable;
  } cnt_ctrl_t;

endpackage

// ==== hw/ocl_settings.svh ====
// ------------------------------------------------
// OCL register map and field widths
// ------------------------------------------------
`ifndef OCL_SETTINGS_SVH
`define OCL_SETTINGS_SVH

// Bus widths
`define OCL_ADDR_W 32
`define OCL_DATA_W 32

// Register field widths
`define OCL_VLED_W  16
`define OCL_COUNT_W 16
`define OCL_TICK_W  8

// Register addresses
`define OCL_HELLO_ADDR      32'h0000_0500
`define OCL_VLED_ADDR       32'h0000_0504
`define OCL_CNT_CTRL_ADDR   32'h0000_0510
`define OCL_TICK_VALUE_ADDR 32'h0000_0514
`define OCL_LOAD_VALUE_ADDR 32'h0000_0518
`define OCL_WATERMARK_ADDR  32'h0000_051C
`define OCL_CNT_STATUS_ADDR 32'h0000_0520

// Read data for any unmapped address
`define OCL_UNIMPL_VALUE 32'hdead_beef

// Control word bits
`define OCL_CTRL_ENABLE_BIT  0
`define OCL_CTRL_LOAD_BIT    1
`define OCL_CTRL_CLEAR_BIT   2
`define OCL_CTRL_ONESHOT_BIT 3

// Watermark flag in the status word
`define OCL_STAT_GE_BIT 24

`endif

// ==== hw/ocl_slave.sv ====
// ------------------------------------------------
// OCL AXI4-Lite slave and register decode
// ------------------------------------------------
`include "ocl_settings.svh"

module ocl_slave
  import ocl_bus_pkg::*;
  import ocl_regs_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  // Write address
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  // Write data
  input  logic       wvalid,
  input  axil_data_t wdata,
  output logic       wready,
  // Write response
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  // Read address
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  // Read data
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready,
  // Decoded register writes
  output logic       hello_wr,
  output logic       ctrl_wr,
  output logic       tick_wr,
  output logic       load_wr,
  output logic       mark_wr,
  output axil_data_t wr_data,
  // Register read sources
  input  axil_data_t hello_swapped,
  input  vled_t      vled_value,
  input  axil_data_t cnt_status
);

  logic       wr_active;
  axil_addr_t wr_addr;
  logic       wr_fire;
  logic       ar_pend;
  axil_addr_t rd_addr;
  axil_data_t rd_mux;

  // ------------------------------------------------
  // Write address and data
  // ------------------------------------------------
  // One write at a time, held open until the response goes out
  assign awready = !wr_active;
  assign wready  = wr_active && wvalid && !bvalid;
  assign wr_fire = wvalid && wready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (awvalid && awready) begin
      wr_active <= 1'b1;
    end else if (bvalid && bready) begin
      wr_active <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr <= awaddr;
    end
  end

  // Write strobes, one per register
  // VLED is read-only, unmapped addresses hit nothing
  assign hello_wr = wr_fire && (wr_addr == `OCL_HELLO_ADDR);
  assign ctrl_wr  = wr_fire && (wr_addr == `OCL_CNT_CTRL_ADDR);
  assign tick_wr  = wr_fire && (wr_addr == `OCL_TICK_VALUE_ADDR);
  assign load_wr  = wr_fire && (wr_addr == `OCL_LOAD_VALUE_ADDR);
  assign mark_wr  = wr_fire && (wr_addr == `OCL_WATERMARK_ADDR);
  assign wr_data  = wdata;

  // ------------------------------------------------
  // Write response
  // ------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end
  end

  assign bresp = AXIL_RESP_OKAY;

  // ------------------------------------------------
  // Read address
  // ------------------------------------------------
  // Blocked while a read is pending or its data unacknowledged
  assign arready = !ar_pend && !rvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ar_pend <= 1'b0;
    end else begin
      ar_pend <= arvalid && arready;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr <= araddr;
    end
  end

  // Read source select
  always_comb begin
    case (rd_addr)
      `OCL_HELLO_ADDR:      rd_mux = hello_swapped;
      `OCL_VLED_ADDR:       rd_mux = {{(`OCL_DATA_W-`OCL_VLED_W){1'b0}}, vled_value};
      `OCL_CNT_STATUS_ADDR: rd_mux = cnt_status;
      default:              rd_mux = `OCL_UNIMPL_VALUE;
    endcase
  end

  // ------------------------------------------------
  // Read data
  // ------------------------------------------------
  // Data lands two cycles after the address handshake
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end else if (ar_pend) begin
      rvalid <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_pend) begin
      rdata <= rd_mux;
    end
  end

  assign rresp = AXIL_RESP_OKAY;

  // Responses hold under back-pressure
  a_bvalid_hold: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid
  );

  a_rvalid_hold: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata)
  );

  // Never more than one register strobed
  a_wr_onehot: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $onehot0({hello_wr, ctrl_wr, tick_wr, load_wr, mark_wr})
  );

endmodule

// ==== hw/tick_counter.sv ====
// ------------------------------------------------
// Prescaled tick counter
// ------------------------------------------------
`include "ocl_settings.svh"

module tick_counter
  import ocl_bus_pkg::*;
  import ocl_regs_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       ctrl_wr,
  input  logic       tick_wr,
  input  logic       load_wr,
  input  logic       mark_wr,
  input  axil_data_t wr_data,
  output axil_data_t cnt_status
);

  cnt_ctrl_t ctrl_q;
  tick_t     tick_q;
  count_t    load_q;
  count_t    mark_q;
  tick_t     presc_q;
  count_t    count_q;
  logic      tick_hit;
  logic      cnt_ge_mark;

  // ------------------------------------------------
  // Control and setting registers
  // ------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q <= '0;
    end else begin
      // Load and clear are single-cycle strobes
      ctrl_q.load  <= ctrl_wr && wr_data[`OCL_CTRL_LOAD_BIT];
      ctrl_q.clear <= ctrl_wr && wr_data[`OCL_CTRL_CLEAR_BIT];
      // Enable and oneshot stick until rewritten
      if (ctrl_wr) begin
        ctrl_q.enable  <= wr_data[`OCL_CTRL_ENABLE_BIT];
        ctrl_q.oneshot <= wr_data[`OCL_CTRL_ONESHOT_BIT];
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_q <= '0;
      load_q <= '0;
      mark_q <= '0;
    end else begin
      if (tick_wr) begin
        tick_q <= wr_data[`OCL_TICK_W-1:0];
      end
      if (load_wr) begin
        load_q <= wr_data[`OCL_COUNT_W-1:0];
      end
      if (mark_wr) begin
        mark_q <= wr_data[`OCL_COUNT_W-1:0];
      end
    end
  end

  // ------------------------------------------------
  // Prescaler and count
  // ------------------------------------------------
  // Prescaler wraps once it reaches the tick value
  assign tick_hit = (presc_q >= tick_q);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      presc_q <= '0;
      count_q <= '0;
    end else if (ctrl_q.clear) begin
      presc_q <= '0;
      count_q <= '0;
    end else if (ctrl_q.load) begin
      // Prescaler keeps its phase across a load
      count_q <= load_q;
    end else if (ctrl_q.enable) begin
      if (tick_hit) begin
        presc_q <= '0;
        // Oneshot parks the count at all ones
        if (!(ctrl_q.oneshot && (&count_q))) begin
          count_q <= count_q + 1'b1;
        end
      end else begin
        presc_q <= presc_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Status word
  // ------------------------------------------------
  assign cnt_ge_mark = (count_q >= mark_q);

  always_comb begin
    cnt_status                              = '0;
    cnt_status[`OCL_COUNT_W-1:0]            = count_q;
    cnt_status[`OCL_COUNT_W +: `OCL_TICK_W] = presc_q;
    cnt_status[`OCL_STAT_GE_BIT]            = cnt_ge_mark;
  end

  // Count only moves when enabled or right after a control write
  a_count_hold: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (!ctrl_q.enable && !$past(ctrl_wr)) |=> $stable(count_q)
  );

endmodule

// ==== test/tb_cl_hello_top.sv ====
// --------------------------------------------------
// Testbench for the hello-world custom logic
// --------------------------------------------------
`include "ocl_settings.svh"

module tb_cl_hello_top
  import ocl_bus_pkg::*;
  import ocl_regs_pkg::*;
;

  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DLY    = 2;
  localparam int STEP_CYCLES  = 12;
  localparam axil_data_t ALL  = 32'hffff_ffff;
  localparam axil_data_t NONE = 32'h0000_0000;

  // Table row kinds
  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_DIP, OP_IDLE} op_t;

  typedef struct packed {
    op_t        op;
    axil_addr_t addr;
    axil_data_t data;
    axil_data_t exp;
    axil_data_t mask;
  } step_t;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  axil_data_t wdata;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       rready;
  vled_t      status_vdip;
  vled_t      status_vled;

  step_t      steps[$];
  integer     seed;
  int         check_cnt;
  int         error_cnt;
  int         step_idx;
  int         cycle_cnt;
  int         limit_cycles;

  cl_hello_top cl_hello_top_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  // 40 unit clock period
  initial clk_main_a0 = 1'b0;
  always #20 clk_main_a0 = ~clk_main_a0;

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------
  always @(posedge clk_main_a0) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= limit_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_data(input string name, input axil_data_t got,
                            input axil_data_t exp, input axil_data_t mask);
    check_cnt++;
    if ((got & mask) !== (exp & mask)) begin
      error_cnt++;
      $display("FAILED t=%0t %s: got %h, expected %h (step %0d)",
               $time, name, got, exp, step_idx);
    end
  endtask

  task automatic check_vled(input string name, input vled_t got,
                            input vled_t exp, input vled_t mask);
    check_cnt++;
    if ((got & mask) !== (exp & mask)) begin
      error_cnt++;
      $display("FAILED t=%0t %s: got %h, expected %h (step %0d)",
               $time, name, got, exp, step_idx);
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("FAILED t=%0t %s: got %0d, expected %0d (step %0d)",
               $time, name, got, exp, step_idx);
    end
  endtask

  // Read data due 2 cycles after the address handshake
  task automatic check_latency(input string name, input int got);
    check_cnt++;
    if (got != 2) begin
      error_cnt++;
      $display("FAILED t=%0t %s: got %0d, expected 2 (step %0d)",
               $time, name, got, step_idx);
    end
  endtask

  // --------------------------------------------------
  // Bus transfers
  // --------------------------------------------------
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
    int delay;
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    awvalid = 1'b1;
    awaddr  = addr;
    @(negedge clk_main_a0);
    while (!awready) @(negedge clk_main_a0);
    // Address taken on this edge
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    @(negedge clk_main_a0);
    while (!wready) @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    wvalid = 1'b0;
    // Random back-pressure on the response
    delay = $random(seed) & 3;
    repeat (delay) begin
      @(posedge clk_main_a0);
      #DRIVE_DLY;
    end
    bready = 1'b1;
    @(negedge clk_main_a0);
    while (!bvalid) @(negedge clk_main_a0);
    resp = bresp;
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp, output int lat);
    int   delay;
    int   cyc;
    logic done;
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk_main_a0);
    while (!arready) @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    arvalid = 1'b0;
    delay   = $random(seed) & 3;
    cyc     = 0;
    lat     = 0;
    done    = 1'b0;
    // One pass per cycle, latency counted from the handshake
    while (!done) begin
      if (cyc >= delay) rready = 1'b1;
      @(negedge clk_main_a0);
      cyc++;
      if (rvalid && lat == 0) lat = cyc;
      if (rvalid && rready) begin
        done = 1'b1;
        data = rdata;
        resp = rresp;
      end
      @(posedge clk_main_a0);
      #DRIVE_DLY;
    end
    rready = 1'b0;
  endtask

  function automatic void add_step(op_t op, axil_addr_t addr, axil_data_t data,
                                   axil_data_t exp, axil_data_t mask);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    s.mask = mask;
    steps.push_back(s);
  endfunction

  // --------------------------------------------------
  // Stimulus table and main sequence
  // --------------------------------------------------
  initial begin
    axil_data_t rd;
    axil_resp_t resp;
    int         lat;
    // Hello-world byte swap
    add_step(OP_WRITE, `OCL_HELLO_ADDR, 32'h1234_5678, NONE, NONE);
    add_step(OP_READ, `OCL_HELLO_ADDR, NONE, 32'h7856_3412, ALL);
    // LED shadow and DIP masking
    add_step(OP_READ, `OCL_VLED_ADDR, NONE, 32'h0000_5678, ALL);
    add_step(OP_DIP, NONE, 32'h0000_f0f0, 32'h0000_5070, 32'h0000_ffff);
    add_step(OP_DIP, NONE, 32'h0000_00ff, 32'h0000_0078, 32'h0000_ffff);
    // Unmapped reads, writes that must change nothing
    add_step(OP_READ, 32'h0000_0600, NONE, 32'hdead_beef, ALL);
    add_step(OP_READ, `OCL_CNT_CTRL_ADDR, NONE, 32'hdead_beef, ALL);
    add_step(OP_WRITE, 32'h0000_0508, 32'hffff_ffff, NONE, NONE);
    add_step(OP_WRITE, `OCL_VLED_ADDR, 32'h0000_0000, NONE, NONE);
    add_step(OP_READ, `OCL_HELLO_ADDR, NONE, 32'h7856_3412, ALL);
    add_step(OP_READ, `OCL_VLED_ADDR, NONE, 32'h0000_5678, ALL);
    // Count 0 against watermark 0 sets the flag
    add_step(OP_READ, `OCL_CNT_STATUS_ADDR, NONE, 32'h0100_0000, ALL);
    // Load with enable low, watermark compare, clear
    add_step(OP_WRITE, `OCL_LOAD_VALUE_ADDR, 32'h0000_1234, NONE, NONE);
    add_step(OP_WRITE, `OCL_WATERMARK_ADDR, 32'h0000_2000, NONE, NONE);
    add_step(OP_WRITE, `OCL_CNT_CTRL_ADDR, 32'h0000_0002, NONE, NONE);
    add_step(OP_READ, `OCL_CNT_STATUS_ADDR, NONE, 32'h0000_1234, ALL);
    add_step(OP_WRITE, `OCL_WATERMARK_ADDR, 32'h0000_1234, NONE, NONE);
    add_step(OP_READ, `OCL_CNT_STATUS_ADDR, NONE, 32'h0100_1234, ALL);
    add_step(OP_WRITE, `OCL_WATERMARK_ADDR, 32'h0000_1235, NONE, NONE);
    add_step(OP_READ, `OCL_CNT_STATUS_ADDR, NONE, 32'h0000_1234, ALL);
    add_step(OP_WRITE, `OCL_CNT_CTRL_ADDR, 32'h0000_0004, NONE, NONE);
    add_step(OP_READ, `OCL_CNT_STATUS_ADDR, NONE, 32'h0000_0000, ALL);
    // Oneshot run from fff0 with tick 0
    add_step(OP_WRITE, `OCL_LOAD_VALUE_ADDR, 32'h0000_fff0, NONE, NONE);
    add_step(OP_WRITE, `OCL_TICK_VALUE_ADDR, 32'h0000_0000, NONE, NONE);
    add_step(OP_WRITE, `OCL_WATERMARK_ADDR, 32'h0000_fff8, NONE, NONE);
    add_step(OP_WRITE, `OCL_CNT_CTRL_ADDR, 32'h0000_000b, NONE, NONE);
    add_step(OP_IDLE, NONE, 32'd40, NONE, NONE);
    add_step(OP_READ, `OCL_CNT_STATUS_ADDR, NONE, 32'h0100_ffff, ALL);
    add_step(OP_IDLE, NONE, 32'd20, NONE, NONE);
    add_step(OP_READ, `OCL_CNT_STATUS_ADDR, NONE, 32'h0100_ffff, ALL);

    limit_cycles    = steps.size() * STEP_CYCLES + RESET_CYCLES;
    seed            = 32'h8be68499;
    cycle_cnt       = 0;
    check_cnt       = 0;
    error_cnt       = 0;
    step_idx        = 0;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    status_vdip     = '0;

    repeat (RESET_CYCLES) @(posedge clk_main_a0);
    #DRIVE_DLY;
    rst_main_n_sync = 1'b1;

    foreach (steps[i]) begin
      step_idx = i;
      case (steps[i].op)
        OP_WRITE: begin
          axil_write(steps[i].addr, steps[i].data, resp);
          check_resp("bresp", resp, AXIL_RESP_OKAY);
        end
        OP_READ: begin
          axil_read(steps[i].addr, rd, resp, lat);
          check_data("rdata", rd, steps[i].exp, steps[i].mask);
          check_resp("rresp", resp, AXIL_RESP_OKAY);
          check_latency("rvalid latency", lat);
        end
        OP_DIP: begin
          @(posedge clk_main_a0);
          #DRIVE_DLY;
          status_vdip = steps[i].data[15:0];
          // Synchronizer plus output register, with margin
          repeat (6) @(posedge clk_main_a0);
          @(negedge clk_main_a0);
          check_vled("status_vled", status_vled, steps[i].exp[15:0], steps[i].mask[15:0]);
        end
        default: begin
          repeat (steps[i].data) @(posedge clk_main_a0);
          #DRIVE_DLY;
        end
      endcase
    end

    $display("checks=%0d errors=%0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
